// ==== Bender.yml ====
package:
  name: mpu

sources:
  - src/csr_pkg.sv
  - src/pmp_pkg.sv
  - src/pmp_napot_decode.sv
  - src/pmp_csr_regs.sv
  - src/pmp_checker.sv
  - src/mpu_top.sv
  - target: simulation
    files:
      - tb/tb_mpu.sv

// ==== list.f ====
src/csr_pkg.sv
src/pmp_pkg.sv
src/pmp_napot_decode.sv
src/pmp_csr_regs.sv
src/pmp_checker.sv
src/mpu_top.sv
tb/tb_mpu.sv

// ==== src/csr_pkg.sv ====
// CSR address and data widths, the PMP CSR addresses
// and the privilege-mode enum shared by the MPU and its users
package csr_pkg;

    // Width of a CSR address as issued by the core's CSR file
    localparam int csr_addr_w = 12;

    // Width of CSR read and write data on an RV32 core
    localparam int csr_data_w = 32;

    // Configuration registers, four 8-bit entry fields each
    localparam logic [csr_addr_w-1:0] csr_pmpcfg0 = 12'h3a0;

    // Only present when the MPU is built with 8 entries
    localparam logic [csr_addr_w-1:0] csr_pmpcfg1 = 12'h3a1;

    // Address registers follow on consecutive addresses from here
    localparam logic [csr_addr_w-1:0] csr_pmpaddr_base = 12'h3b0;

    // Privilege level of an access or of a CSR instruction
    // Supervisor mode is not implemented, so one bit is enough
    typedef enum logic {
        priv_user    = 1'b0,
        priv_machine = 1'b1
    } priv_mode_e;

endpackage

// ==== src/mpu_top.sv ====
// MPU top level: register block serving the pmpcfg and pmpaddr CSRs
// beside the checker that kills fetch and data accesses
`timescale 1ns/10ps

module mpu_top
    import csr_pkg::*;
    import pmp_pkg::*;
#(
    parameter int pmp_regs = 8
) (
    input  logic                  core_clock_i,
    input  logic                  rst_i,

    // CSR file side
    input  logic [csr_addr_w-1:0] csr_addr_i,
    input  logic [csr_data_w-1:0] csr_wdata_i,
    input  logic                  csr_wr_en_i,
    output logic [csr_data_w-1:0] csr_rdata_o,
    output logic                  csr_exists_o,

    // Instruction fetch check
    input  logic [blk_addr_w-1:0] fetch_addr_i,
    input  priv_mode_e            fetch_mode_i,
    output logic                  fetch_kill_o,

    // Load and store check
    input  logic [blk_addr_w-1:0] data_addr_i,
    input  priv_mode_e            data_mode_i,
    input  logic                  data_write_i,
    output logic                  data_kill_o
);

    // Entry state from the register block to the checker
    logic [pmp_regs-1:0]            entry_lock;
    logic [pmp_regs-1:0]            entry_on;
    logic [pmp_regs-1:0]            entry_x;
    logic [pmp_regs-1:0]            entry_w;
    logic [pmp_regs-1:0]            entry_r;
    logic [pmp_regs*blk_addr_w-1:0] entry_mask;
    logic [pmp_regs*blk_addr_w-1:0] entry_match;

    // CSR instructions run at the privilege level of the fetch stream
    pmp_csr_regs #(
        .pmp_regs (pmp_regs)
    ) u_csr_regs (
        .core_clock_i  (core_clock_i),
        .rst_i         (rst_i),
        .csr_addr_i    (csr_addr_i),
        .csr_wdata_i   (csr_wdata_i),
        .csr_wr_en_i   (csr_wr_en_i),
        .mode_i        (fetch_mode_i),
        .csr_rdata_o   (csr_rdata_o),
        .csr_exists_o  (csr_exists_o),
        .entry_lock_o  (entry_lock),
        .entry_on_o    (entry_on),
        .entry_x_o     (entry_x),
        .entry_w_o     (entry_w),
        .entry_r_o     (entry_r),
        .entry_mask_o  (entry_mask),
        .entry_match_o (entry_match)
    );

    pmp_checker #(
        .pmp_regs (pmp_regs)
    ) u_checker (
        .entry_lock_i  (entry_lock),
        .entry_on_i    (entry_on),
        .entry_x_i     (entry_x),
        .entry_w_i     (entry_w),
        .entry_r_i     (entry_r),
        .entry_mask_i  (entry_mask),
        .entry_match_i (entry_match),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_mode_i  (fetch_mode_i),
        .fetch_kill_o  (fetch_kill_o),
        .data_addr_i   (data_addr_i),
        .data_mode_i   (data_mode_i),
        .data_write_i  (data_write_i),
        .data_kill_o   (data_kill_o)
    );

endmodule

// ==== src/pmp_checker.sv ====
// PMP checker: per-entry region compare for the fetch and data ports,
// lowest-entry priority pick and the kill decision for each port
`timescale 1ns/10ps

module pmp_checker
    import csr_pkg::*;
    import pmp_pkg::*;
#(
    parameter int pmp_regs = 8
) (
    input  logic [pmp_regs-1:0]            entry_lock_i,
    input  logic [pmp_regs-1:0]            entry_on_i,
    input  logic [pmp_regs-1:0]            entry_x_i,
    input  logic [pmp_regs-1:0]            entry_w_i,
    input  logic [pmp_regs-1:0]            entry_r_i,
    input  logic [pmp_regs*blk_addr_w-1:0] entry_mask_i,
    input  logic [pmp_regs*blk_addr_w-1:0] entry_match_i,
    input  logic [blk_addr_w-1:0]          fetch_addr_i,
    input  priv_mode_e                     fetch_mode_i,
    output logic                           fetch_kill_o,
    input  logic [blk_addr_w-1:0]          data_addr_i,
    input  priv_mode_e                     data_mode_i,
    input  logic                           data_write_i,
    output logic                           data_kill_o
);

    logic [blk_addr_w-1:0] mask_e [pmp_regs];
    logic [blk_addr_w-1:0] match_e [pmp_regs];
    logic [pmp_regs-1:0]   fetch_hit;
    logic [pmp_regs-1:0]   data_hit;
    logic [pmp_regs-1:0]   fetch_win;
    logic [pmp_regs-1:0]   data_win;
    logic [pmp_regs-1:0]   data_perm;

    // Keep only the lowest set bit, which is the highest-priority entry
    function automatic logic [pmp_regs-1:0] lowest_set(input logic [pmp_regs-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    // Kill decision for one access given the one-hot winning entry
    function automatic logic access_kill(
        input priv_mode_e          mode,
        input logic [pmp_regs-1:0] winner,
        input logic [pmp_regs-1:0] perm,
        input logic [pmp_regs-1:0] lock
    );
        logic allowed;
        logic locked;
        // Both are zero when no entry matched at all
        allowed = |(winner & perm);
        locked = |(winner & lock);
        if (mode == priv_machine) begin
            // Machine mode is only held back by a locked entry
            return locked && !allowed;
        end
        // User mode needs a matching entry that grants the permission
        return !allowed;
    endfunction

    // Both ports compare against every enabled region in parallel
    always_comb begin
        for (int i = 0; i < pmp_regs; i++) begin
            mask_e[i] = entry_mask_i[i*blk_addr_w +: blk_addr_w];
            match_e[i] = entry_match_i[i*blk_addr_w +: blk_addr_w];
            fetch_hit[i] = entry_on_i[i] && ((fetch_addr_i & mask_e[i]) == match_e[i]);
            data_hit[i] = entry_on_i[i] && ((data_addr_i & mask_e[i]) == match_e[i]);
        end
    end

    assign fetch_win = lowest_set(fetch_hit);
    assign data_win = lowest_set(data_hit);

    // Stores test w and loads test r, fetches always test x
    assign data_perm = data_write_i ? entry_w_i : entry_r_i;

    assign fetch_kill_o = access_kill(fetch_mode_i, fetch_win, entry_x_i, entry_lock_i);
    assign data_kill_o = access_kill(data_mode_i, data_win, data_perm, entry_lock_i);

endmodule

// ==== src/pmp_csr_regs.sv ====
// PMP register block: per-entry lock, mode, permission and address registers,
// CSR write with lock and privilege checks, readback and existence decode,
// and the decoded region masks handed to the checker
`timescale 1ns/10ps

module pmp_csr_regs
    import csr_pkg::*;
    import pmp_pkg::*;
#(
    parameter int pmp_regs = 8
) (
    input  logic                           core_clock_i,
    input  logic                           rst_i,
    input  logic [csr_addr_w-1:0]          csr_addr_i,
    input  logic [csr_data_w-1:0]          csr_wdata_i,
    input  logic                           csr_wr_en_i,
    input  priv_mode_e                     mode_i,
    output logic [csr_data_w-1:0]          csr_rdata_o,
    output logic                           csr_exists_o,
    output logic [pmp_regs-1:0]            entry_lock_o,
    output logic [pmp_regs-1:0]            entry_on_o,
    output logic [pmp_regs-1:0]            entry_x_o,
    output logic [pmp_regs-1:0]            entry_w_o,
    output logic [pmp_regs-1:0]            entry_r_o,
    output logic [pmp_regs*blk_addr_w-1:0] entry_mask_o,
    output logic [pmp_regs*blk_addr_w-1:0] entry_match_o
);

    // Number of implemented pmpcfg registers, 1 or 2
    localparam int cfg_regs = pmp_regs / cfg_fields;
    // Zero bits above the stored address on readback
    localparam int addr_pad_w = csr_data_w - pmp_addr_w - pmp_addr_lsb;

    // Control state of every entry
    logic [pmp_regs-1:0] lock_q;
    logic [pmp_regs-1:0] on_q;
    logic [pmp_regs-1:0] x_q;
    logic [pmp_regs-1:0] w_q;
    logic [pmp_regs-1:0] r_q;

    // Stored address and its decoded region, only valid while the entry is on
    logic [pmp_addr_w-1:0] addr_q [pmp_regs];
    logic [blk_addr_w-1:0] mask_q [pmp_regs];
    logic [blk_addr_w-1:0] match_q [pmp_regs];

    logic                   machine_mode;
    logic                   wr_ok;
    logic                   cfg_upper;
    logic                   cfg_hit;
    logic                   addr_hit;
    logic [csr_addr_w-1:0]  addr_off;
    logic [blk_addr_w-1:0]  wr_mask;
    logic [blk_addr_w-1:0]  wr_match;
    logic [cfg_field_w-1:0] wr_field [pmp_regs];
    logic [pmp_regs-1:0]    cfg_wr_en;
    logic [pmp_regs-1:0]    addr_wr_en;
    logic [csr_data_w-1:0]  cfg_word;
    logic [csr_data_w-1:0]  addr_word;

    assign machine_mode = (mode_i == priv_machine);
    // CSR writes only land from machine mode
    assign wr_ok = csr_wr_en_i && machine_mode;

    // pmpcfg1 only exists in the 8-entry build
    assign cfg_upper = (cfg_regs > 1) && (csr_addr_i == csr_pmpcfg1);
    assign cfg_hit = (csr_addr_i == csr_pmpcfg0) || cfg_upper;

    // Addresses below the base wrap to large offsets and miss
    assign addr_off = csr_addr_i - csr_pmpaddr_base;
    assign addr_hit = (addr_off < pmp_regs);

    // The region is decoded once, from the write data, and stored with the address
    pmp_napot_decode u_napot_decode (
        .addr_i  (csr_wdata_i[pmp_addr_lsb +: pmp_addr_w]),
        .mask_o  (wr_mask),
        .match_o (wr_match)
    );

    // Per-entry write enables, a locked entry ignores both kinds of write
    always_comb begin
        for (int i = 0; i < pmp_regs; i++) begin
            wr_field[i] = csr_wdata_i[(i % cfg_fields) * cfg_field_w +: cfg_field_w];
            cfg_wr_en[i] = wr_ok && cfg_hit && !lock_q[i]
                           && ((i / cfg_fields) == int'(cfg_upper));
            addr_wr_en[i] = wr_ok && addr_hit && !lock_q[i] && (addr_off == i);
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (rst_i) begin
            lock_q <= '0;
            on_q <= '0;
            x_q <= '0;
            w_q <= '0;
            r_q <= '0;
        end else begin
            for (int i = 0; i < pmp_regs; i++) begin
                if (cfg_wr_en[i]) begin
                    lock_q[i] <= wr_field[i][cfg_l_bit];
                    // TOR and NA4 fall back to OFF
                    on_q[i] <= (wr_field[i][cfg_a_hi:cfg_a_lo] == amode_napot);
                    x_q[i] <= wr_field[i][cfg_x_bit];
                    w_q[i] <= wr_field[i][cfg_w_bit];
                    r_q[i] <= wr_field[i][cfg_r_bit];
                end
            end
        end
    end

    always_ff @(posedge core_clock_i) begin
        for (int i = 0; i < pmp_regs; i++) begin
            if (addr_wr_en[i]) begin
                addr_q[i] <= csr_wdata_i[pmp_addr_lsb +: pmp_addr_w];
                mask_q[i] <= wr_mask;
                match_q[i] <= wr_match;
            end
        end
    end

    // Readback of the selected pmpcfg register, four fields side by side
    always_comb begin
        int e;
        cfg_word = '0;
        for (int f = 0; f < cfg_fields; f++) begin
            e = cfg_upper ? cfg_fields + f : f;
            cfg_word[f*cfg_field_w + cfg_r_bit] = r_q[e];
            cfg_word[f*cfg_field_w + cfg_w_bit] = w_q[e];
            cfg_word[f*cfg_field_w + cfg_x_bit] = x_q[e];
            // A reads back as OFF or NAPOT only
            cfg_word[f*cfg_field_w + cfg_a_lo +: 2] = on_q[e] ? amode_napot : amode_off;
            cfg_word[f*cfg_field_w + cfg_l_bit] = lock_q[e];
        end
    end

    // pmpaddr readback with the top bits zero and the low bits forced to ones
    always_comb begin
        addr_word = '0;
        for (int i = 0; i < pmp_regs; i++) begin
            if (addr_off == i) begin
                addr_word = {{addr_pad_w{1'b0}}, addr_q[i], {pmp_addr_lsb{1'b1}}};
            end
        end
    end

    assign csr_rdata_o = cfg_hit ? cfg_word : (addr_hit ? addr_word : '0);
    // The registers are machine-mode only, so a user-mode access sees nothing
    assign csr_exists_o = (cfg_hit || addr_hit) && machine_mode;

    assign entry_lock_o = lock_q;
    assign entry_on_o = on_q;
    assign entry_x_o = x_q;
    assign entry_w_o = w_q;
    assign entry_r_o = r_q;

    // Flatten the regions for the checker, entry 0 in the low bits
    always_comb begin
        for (int i = 0; i < pmp_regs; i++) begin
            entry_mask_o[i*blk_addr_w +: blk_addr_w] = mask_q[i];
            entry_match_o[i*blk_addr_w +: blk_addr_w] = match_q[i];
        end
    end

endmodule

// ==== src/pmp_napot_decode.sv ====
// NAPOT decoder turning a written pmpaddr value into the
// block-address compare mask and match pattern of its region
`timescale 1ns/10ps

module pmp_napot_decode
    import pmp_pkg::*;
(
    input  logic [pmp_addr_w-1:0] addr_i,
    output logic [blk_addr_w-1:0] mask_o,
    output logic [blk_addr_w-1:0] match_o
);

    // Full pmpaddr width with the forced low ones put back in
    localparam int full_w = pmp_addr_w + pmp_addr_lsb;
    // pmpaddr counts 4-byte words, so block bit 0 sits at pmpaddr bit 3
    localparam int blk_lsb = 3;
    localparam int blk_msb = blk_lsb + blk_addr_w - 1;

    logic [full_w-1:0] value;
    logic [full_w-1:0] mask_full;
    logic [full_w-1:0] base_full;
    logic              ones_run;
    logic              beyond;

    always_comb begin
        value = {addr_i, {pmp_addr_lsb{1'b1}}};
        // A bit is compared only once the trailing-ones run has ended below it
        ones_run = 1'b1;
        for (int j = 0; j < full_w; j++) begin
            mask_full[j] = !ones_run;
            ones_run = ones_run & value[j];
        end
        // Clearing the run and the first zero above it leaves the region base
        base_full = value & mask_full;
    end

    // A base at or above 1 GiB can never be reached by a block address
    assign beyond = |base_full[full_w-1:blk_msb+1];

    assign mask_o = mask_full[blk_msb:blk_lsb];
    // Block bit 0 is never compared, so a one there makes the entry unmatchable
    assign match_o = base_full[blk_msb:blk_lsb] | {{(blk_addr_w-1){1'b0}}, beyond};

endmodule

// ==== src/pmp_pkg.sv ====
// PMP entry layout: stored address width, block address width,
// the bit positions inside an 8-bit cfg field and the address-mode enum
package pmp_pkg;

    // Number of pmpaddr bits kept per entry, CSR data bits 29 to 4
    localparam int pmp_addr_w = 26;

    // Lowest pmpaddr bit that is stored
    // The bits below it always read back as ones
    localparam int pmp_addr_lsb = 4;

    // Block address on the check ports, byte address bits 29 to 5
    localparam int blk_addr_w = 25;

    // Each pmpcfg register holds this many fields of this width
    localparam int cfg_fields = 4;
    localparam int cfg_field_w = 8;

    // Bit positions inside one cfg field
    localparam int cfg_r_bit = 0;
    localparam int cfg_w_bit = 1;
    localparam int cfg_x_bit = 2;
    localparam int cfg_a_lo = 3;
    localparam int cfg_a_hi = 4;
    localparam int cfg_l_bit = 7;

    // Address-matching mode held in the A field
    // TOR and NA4 are not supported and are stored as OFF
    typedef enum logic [1:0] {
        amode_off   = 2'b00,
        amode_napot = 2'b11
    } pmp_amode_e;

endpackage

// ==== tb/tb_mpu.sv ====
// Directed testbench for the MPU: clock, reset, LFSR stimulus,
// a reference model of the PMP entries and one task per tested behavior
`timescale 1ns/10ps

module tb_mpu
    import csr_pkg::*;
    import pmp_pkg::*;
();

    localparam int n_entries = 8;

    logic                  core_clock_i;
    logic                  rst_i;
    logic [csr_addr_w-1:0] csr_addr_i;
    logic [csr_data_w-1:0] csr_wdata_i;
    logic                  csr_wr_en_i;
    logic [csr_data_w-1:0] csr_rdata_o;
    logic                  csr_exists_o;
    logic [blk_addr_w-1:0] fetch_addr_i;
    priv_mode_e            fetch_mode_i;
    logic                  fetch_kill_o;
    logic [blk_addr_w-1:0] data_addr_i;
    priv_mode_e            data_mode_i;
    logic                  data_write_i;
    logic                  data_kill_o;

    // Reference copy of the entries, cfg kept in its readback form
    logic [7:0]  ref_cfg [n_entries];
    logic [25:0] ref_addr [n_entries];
    logic [31:0] lfsr_q;

    mpu_top #(
        .pmp_regs (n_entries)
    ) dut0 (
        .core_clock_i (core_clock_i),
        .rst_i        (rst_i),
        .csr_addr_i   (csr_addr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_wr_en_i  (csr_wr_en_i),
        .csr_rdata_o  (csr_rdata_o),
        .csr_exists_o (csr_exists_o),
        .fetch_addr_i (fetch_addr_i),
        .fetch_mode_i (fetch_mode_i),
        .fetch_kill_o (fetch_kill_o),
        .data_addr_i  (data_addr_i),
        .data_mode_i  (data_mode_i),
        .data_write_i (data_write_i),
        .data_kill_o  (data_kill_o)
    );

    always #2 core_clock_i = ~core_clock_i;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, name, exp, got);
            abort_run("First mismatch ends the run");
        end
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit handed out
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // A reads back as NAPOT only when NAPOT was written, bits 6:5 read zero
    function automatic logic [7:0] cfg_readback(input logic [7:0] wr);
        logic [1:0] a;
        a = (wr[4:3] == 2'b11) ? 2'b11 : 2'b00;
        return {wr[7], 2'b00, a, wr[2:0]};
    endfunction

    function automatic logic [31:0] model_cfg_word(input int reg_idx);
        logic [31:0] w;
        for (int f = 0; f < 4; f++) begin
            w[f*8 +: 8] = ref_cfg[reg_idx*4 + f];
        end
        return w;
    endfunction

    // Byte range test straight from the NAPOT size rule
    function automatic logic region_hit(input int i, input logic [24:0] blk);
        logic [29:0] value;
        longint      base;
        longint      size;
        longint      byte_addr;
        int          k;
        value = {ref_addr[i], 4'hf};
        k = 0;
        for (int j = 0; j < 30; j++) begin
            if (value[j] && k == j) begin
                k = j + 1;
            end
        end
        base = (longint'(value) >> k) << (k + 2);
        size = longint'(1) << (k + 3);
        byte_addr = longint'(blk) << 5;
        return (ref_cfg[i][4:3] == 2'b11) && byte_addr >= base && byte_addr < base + size;
    endfunction

    // Kind 0 is a fetch, 1 a load and 2 a store
    function automatic logic model_kill(input logic [24:0] blk, input priv_mode_e mode,
                                        input int kind);
        int   win;
        logic perm;
        win = -1;
        for (int i = n_entries - 1; i >= 0; i--) begin
            if (region_hit(i, blk)) begin
                win = i;
            end
        end
        if (win < 0) begin
            return mode == priv_user;
        end
        perm = (kind == 0) ? ref_cfg[win][2] : (kind == 1) ? ref_cfg[win][0] : ref_cfg[win][1];
        if (mode == priv_machine) begin
            return ref_cfg[win][7] && !perm;
        end
        return !perm;
    endfunction

    // Write lands at the rising edge inside the two falling edges
    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data,
                             input priv_mode_e mode);
        int idx;
        @(negedge core_clock_i);
        csr_addr_i = addr;
        csr_wdata_i = data;
        csr_wr_en_i = 1'b1;
        fetch_mode_i = mode;
        if (mode == priv_machine) begin
            if (addr == csr_pmpcfg0 || addr == csr_pmpcfg1) begin
                for (int f = 0; f < 4; f++) begin
                    idx = (addr == csr_pmpcfg1) ? 4 + f : f;
                    if (!ref_cfg[idx][7]) begin
                        ref_cfg[idx] = cfg_readback(data[f*8 +: 8]);
                    end
                end
            end else if (addr >= csr_pmpaddr_base && addr < csr_pmpaddr_base + n_entries) begin
                idx = addr - csr_pmpaddr_base;
                if (!ref_cfg[idx][7]) begin
                    ref_addr[idx] = data[29:4];
                end
            end
        end
        @(negedge core_clock_i);
        csr_wr_en_i = 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, input priv_mode_e mode,
                            output logic [31:0] rdata, output logic exists);
        @(negedge core_clock_i);
        csr_addr_i = addr;
        csr_wr_en_i = 1'b0;
        fetch_mode_i = mode;
        #1;
        rdata = csr_rdata_o;
        exists = csr_exists_o;
    endtask

    task automatic drive_access(input logic [24:0] fa, input logic [24:0] da,
                                input logic wr, input priv_mode_e mode);
        @(negedge core_clock_i);
        csr_wr_en_i = 1'b0;
        fetch_addr_i = fa;
        data_addr_i = da;
        data_write_i = wr;
        fetch_mode_i = mode;
        data_mode_i = mode;
        #1;
    endtask

    task automatic check_access(input logic [24:0] fa, input logic [24:0] da,
                                input logic wr, input priv_mode_e mode);
        drive_access(fa, da, wr, mode);
        check_value("fetch_kill_o", fetch_kill_o, model_kill(fa, mode, 0));
        check_value("data_kill_o", data_kill_o, model_kill(da, mode, wr ? 2 : 1));
    endtask

    task automatic random_accesses(input int count, input priv_mode_e mode);
        logic [31:0] sel;
        logic [31:0] fa;
        logic [31:0] da;
        logic [31:0] wr;
        for (int n = 0; n < count; n++) begin
            // Half of the addresses fall in the low 512 KiB where the regions sit
            take_bits(1, sel);
            take_bits(sel[0] ? 14 : 25, fa);
            take_bits(1, sel);
            take_bits(sel[0] ? 14 : 25, da);
            take_bits(1, wr);
            check_access(fa[24:0], da[24:0], wr[0], mode);
        end
    endtask

    task automatic apply_reset();
        int cycles;
        @(negedge core_clock_i);
        rst_i = 1'b1;
        repeat (5) @(negedge core_clock_i);
        rst_i = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            ref_cfg[i] = 8'h00;
        end
        // Cleared entries show up as a zero pmpcfg0 and no machine-mode kill
        cycles = 0;
        csr_addr_i = csr_pmpcfg0;
        fetch_mode_i = priv_machine;
        #1;
        while (!(csr_rdata_o === 32'h0 && fetch_kill_o === 1'b0)) begin
            if (cycles == 8) begin
                abort_run("Timeout: PMP entries not cleared after reset");
            end
            @(negedge core_clock_i);
            #1;
            cycles++;
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] rdata;
        logic        exists;
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, model_cfg_word(0));
        check_value("csr_exists_o", exists, 1'b1);
        csr_read(csr_pmpcfg1, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, model_cfg_word(1));
        check_value("csr_exists_o", exists, 1'b1);
        for (int i = 0; i < n_entries; i++) begin
            csr_read(csr_pmpaddr_base + i, priv_machine, rdata, exists);
            check_value("csr_exists_o", exists, 1'b1);
        end
        // pmpcfg2, pmpaddr8 and any user-mode access do not exist
        csr_read(csr_pmpcfg0 + 2, priv_machine, rdata, exists);
        check_value("csr_exists_o", exists, 1'b0);
        csr_read(csr_pmpaddr_base + 8, priv_machine, rdata, exists);
        check_value("csr_exists_o", exists, 1'b0);
        csr_read(csr_pmpcfg0, priv_user, rdata, exists);
        check_value("csr_exists_o", exists, 1'b0);
        csr_read(csr_pmpaddr_base, priv_user, rdata, exists);
        check_value("csr_exists_o", exists, 1'b0);
        random_accesses(16, priv_machine);
        random_accesses(16, priv_user);
    endtask

    task automatic test_write_readback();
        logic [31:0] rdata;
        logic        exists;
        logic [31:0] value;
        // TOR, NA4 and a reserved bit read back without the A field
        csr_write(csr_pmpcfg0, 32'h142d0d1b, priv_machine);
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h0405051b);
        csr_write(csr_pmpcfg1, 32'h1f001b18, priv_machine);
        csr_read(csr_pmpcfg1, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, model_cfg_word(1));
        for (int i = 0; i < n_entries; i++) begin
            take_bits(32, value);
            csr_write(csr_pmpaddr_base + i, value, priv_machine);
            csr_read(csr_pmpaddr_base + i, priv_machine, rdata, exists);
            check_value("csr_rdata_o", rdata, {2'b00, ref_addr[i], 4'hf});
        end
        csr_write(csr_pmpaddr_base + 3, 32'hffff1230, priv_machine);
        csr_read(csr_pmpaddr_base + 3, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h3fff123f);
        // User-mode writes must leave everything as it was
        csr_write(csr_pmpcfg0, 32'hffffffff, priv_user);
        csr_write(csr_pmpaddr_base + 3, 32'h0, priv_user);
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h0405051b);
        csr_read(csr_pmpaddr_base + 3, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h3fff123f);
    endtask

    task automatic test_napot_priority();
        // Entry 0 sits inside entry 1, both inside entry 4, entry 6 covers everything
        csr_write(csr_pmpcfg0, 32'h071b1c19, priv_machine);
        csr_write(csr_pmpcfg1, 32'h001c1f1f, priv_machine);
        csr_write(csr_pmpaddr_base + 0, 32'h000041ff, priv_machine);
        csr_write(csr_pmpaddr_base + 1, 32'h000043ff, priv_machine);
        csr_write(csr_pmpaddr_base + 2, 32'h0000600f, priv_machine);
        csr_write(csr_pmpaddr_base + 3, 32'h3fffffff, priv_machine);
        csr_write(csr_pmpaddr_base + 4, 32'h00007fff, priv_machine);
        // Entry 5 has its base at 1 GiB, out of reach of any block address
        csr_write(csr_pmpaddr_base + 5, 32'h1000000f, priv_machine);
        csr_write(csr_pmpaddr_base + 6, 32'h3fffffff, priv_machine);
        csr_write(csr_pmpaddr_base + 7, 32'h00000000, priv_machine);
        random_accesses(300, priv_user);
    endtask

    task automatic test_machine_mode();
        random_accesses(100, priv_machine);
        // Lock entry 2, the 128-byte region at 0x18000, with read only
        csr_write(csr_pmpcfg0, 32'h07991c19, priv_machine);
        drive_access(25'hc00, 25'hc00, 1'b1, priv_machine);
        check_value("fetch_kill_o", fetch_kill_o, 1'b1);
        check_value("data_kill_o", data_kill_o, 1'b1);
        drive_access(25'hc04, 25'hc03, 1'b1, priv_machine);
        check_value("fetch_kill_o", fetch_kill_o, 1'b0);
        check_value("data_kill_o", data_kill_o, 1'b1);
        drive_access(25'hbff, 25'hc04, 1'b1, priv_machine);
        check_value("data_kill_o", data_kill_o, 1'b0);
        drive_access(25'hbff, 25'hc00, 1'b0, priv_machine);
        check_value("data_kill_o", data_kill_o, 1'b0);
        random_accesses(50, priv_machine);
    endtask

    task automatic test_lock_protection();
        logic [31:0] rdata;
        logic        exists;
        // Entry 2 keeps its locked field while its neighbors take the new one
        csr_write(csr_pmpcfg0, 32'h1f1f1f1f, priv_machine);
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h1f991f1f);
        csr_write(csr_pmpaddr_base + 2, 32'h00007fff, priv_machine);
        csr_read(csr_pmpaddr_base + 2, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h0000600f);
        csr_write(csr_pmpaddr_base + 3, 32'h12345670, priv_machine);
        csr_read(csr_pmpaddr_base + 3, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h1234567f);
        apply_reset();
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h0);
        // With the lock gone entry 2 accepts writes again
        csr_write(csr_pmpcfg0, 32'h00180000, priv_machine);
        csr_read(csr_pmpcfg0, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h00180000);
        csr_write(csr_pmpaddr_base + 2, 32'h00007fff, priv_machine);
        csr_read(csr_pmpaddr_base + 2, priv_machine, rdata, exists);
        check_value("csr_rdata_o", rdata, 32'h00007fff);
    endtask

    initial begin
        core_clock_i = 1'b0;
        rst_i = 1'b1;
        csr_addr_i = '0;
        csr_wdata_i = '0;
        csr_wr_en_i = 1'b0;
        fetch_addr_i = '0;
        fetch_mode_i = priv_machine;
        data_addr_i = '0;
        data_mode_i = priv_machine;
        data_write_i = 1'b0;
        lfsr_q = 32'haf420a21;
        for (int i = 0; i < n_entries; i++) begin
            ref_cfg[i] = 8'h00;
            ref_addr[i] = '0;
        end
        apply_reset();
        test_reset_state();
        test_write_readback();
        test_napot_priority();
        test_machine_mode();
        test_lock_protection();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
